/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_rob_core
RTL_TOP    := rob_core_top
FILELIST   := vlog.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/tb_rob_core.sv */
`default_nettype none

module tb_rob_core;
    timeunit 1ns;
    timeprecision 1ns;

    localparam int eff_none     = 0;
    localparam int eff_write    = 1;
    localparam int eff_redirect = 2;

    // Cycle budget per test, roughly 4 cycles per entry plus drain and a 34 cycle sweep
    localparam int test_len = 4 * (5 * 4 + 6) + (rob_pkg::rob_size * 4 + 10)
                            + (4 * 4 + 10) + (8 * 4 + 6) + (6 * 4 + 6) + 5 * 34;
    localparam int timeout_limit = 2 * test_len + 10;

    logic                        clk;
    logic                        reset;
    logic                        alloc;
    logic [31:0]                 alloc_pc;
    logic [31:0]                 alloc_addr_miss;
    logic [4:0]                  alloc_rd;
    logic [rob_pkg::instr_w-1:0] alloc_instr_type;
    logic                        stall;
    logic                        full;
    logic [rob_pkg::idx_w-1:0]   alloc_idx;
    logic                        exe_complete;
    logic [rob_pkg::idx_w-1:0]   exe_idx;
    logic [31:0]                 exe_value;
    logic [rob_pkg::exc_w-1:0]   exe_exception;
    logic                        cache_complete;
    logic [rob_pkg::idx_w-1:0]   cache_idx;
    logic [31:0]                 cache_value;
    logic [4:0]                  rs_addr;
    logic [31:0]                 rs_data;
    logic                        redirect;
    logic [31:0]                 redirect_pc;
    logic [31:0]                 redirect_miss_addr;
    logic [31:0]                 retired_count;

    // Reference model of the buffer, indexed by entry tag
    logic [31:0]                 ref_pc    [rob_pkg::rob_size];
    logic [31:0]                 ref_miss  [rob_pkg::rob_size];
    logic [31:0]                 ref_value [rob_pkg::rob_size];
    logic [4:0]                  ref_rd    [rob_pkg::rob_size];
    logic [rob_pkg::instr_w-1:0] ref_type  [rob_pkg::rob_size];
    logic [rob_pkg::exc_w-1:0]   ref_exc   [rob_pkg::rob_size];
    logic [31:0]                 shadow    [32];
    int                          order_q[$];
    int                          batch[$];

    logic [31:0] lfsr_state;
    logic        redirect_due;
    logic [31:0] due_pc;
    logic [31:0] due_miss;
    int          exp_tail;
    int          exp_retired;
    int          redirect_count;
    int          cycle_count;
    int          error_count;
    int          tests_run;
    int          tests_failed;
    string       test_name;

    rob_core_top i_dut (
        .clk                (clk),
        .reset              (reset),
        .alloc              (alloc),
        .alloc_pc           (alloc_pc),
        .alloc_addr_miss    (alloc_addr_miss),
        .alloc_rd           (alloc_rd),
        .alloc_instr_type   (alloc_instr_type),
        .stall              (stall),
        .full               (full),
        .alloc_idx          (alloc_idx),
        .exe_complete       (exe_complete),
        .exe_idx            (exe_idx),
        .exe_value          (exe_value),
        .exe_exception      (exe_exception),
        .cache_complete     (cache_complete),
        .cache_idx          (cache_idx),
        .cache_value        (cache_value),
        .rs_addr            (rs_addr),
        .rs_data            (rs_data),
        .redirect           (redirect),
        .redirect_pc        (redirect_pc),
        .redirect_miss_addr (redirect_miss_addr),
        .retired_count      (retired_count)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] take_bits(input int nbits);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < nbits; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
        end
        return r;
    endfunction

    function automatic logic [4:0] pick_dest();
        logic [4:0] rd;
        rd = 5'(take_bits(5));
        return (rd == 5'd0) ? 5'd1 : rd;
    endfunction

    // Expected effect of retiring one entry
    function automatic int commit_effect(input logic [rob_pkg::instr_w-1:0] itype,
                                         input logic [4:0] rd,
                                         input logic [rob_pkg::exc_w-1:0] exc);
        if (exc != rob_pkg::exc_none) begin
            return eff_redirect;
        end
        if (itype == rob_pkg::itype_store || rd == 5'd0) begin
            return eff_none;
        end
        return eff_write;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected === actual) else begin
            $display("FAIL %s %s: expected 0x%0h, actual 0x%0h", test_name, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        assert (cond) else begin
            $display("ERROR %s: %s", test_name, msg);
            error_count++;
        end
    endtask

    // Holds the request until the buffer accepts it
    task automatic alloc_entry(input logic [rob_pkg::instr_w-1:0] itype, input logic [4:0] rd);
        logic [31:0] pc;
        logic [31:0] miss;
        pc = take_bits(32) & ~32'h3;
        miss = take_bits(32);
        @(posedge clk);
        alloc            <= 1'b1;
        alloc_pc         <= pc;
        alloc_addr_miss  <= miss;
        alloc_rd         <= rd;
        alloc_instr_type <= itype;
        do @(posedge clk); while (full || stall);
        check_value("alloc_idx", exp_tail, alloc_idx);
        ref_pc[exp_tail]   = pc;
        ref_miss[exp_tail] = miss;
        ref_rd[exp_tail]   = rd;
        ref_type[exp_tail] = itype;
        order_q.push_back(exp_tail);
        batch.push_back(exp_tail);
        exp_tail = (exp_tail + 1) % rob_pkg::rob_size;
        alloc <= 1'b0;
    endtask

    // Loads come back on the cache port, everything else on execute
    task automatic complete_entry(input int idx, input logic [rob_pkg::exc_w-1:0] exc);
        logic [31:0] val;
        val = take_bits(32);
        ref_value[idx] = val;
        ref_exc[idx]   = exc;
        @(posedge clk);
        if (ref_type[idx] == rob_pkg::itype_load) begin
            cache_complete <= 1'b1;
            cache_idx      <= rob_pkg::idx_w'(idx);
            cache_value    <= val;
        end else begin
            exe_complete  <= 1'b1;
            exe_idx       <= rob_pkg::idx_w'(idx);
            exe_value     <= val;
            exe_exception <= exc;
        end
        @(posedge clk);
        exe_complete   <= 1'b0;
        cache_complete <= 1'b0;
    endtask

    task automatic complete_batch();
        int j;
        int t;
        for (int i = batch.size() - 1; i > 0; i--) begin
            j = int'(take_bits(8)) % (i + 1);
            t = batch[i];
            batch[i] = batch[j];
            batch[j] = t;
        end
        foreach (batch[i]) begin
            complete_entry(batch[i], rob_pkg::exc_none);
        end
        batch.delete();
    endtask

    task automatic drain();
        while (order_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic sweep_regs();
        for (int r = 0; r < 32; r++) begin
            @(posedge clk);
            rs_addr <= 5'(r);
            @(negedge clk);
            check_value($sformatf("x%0d", r), shadow[r], rs_data);
        end
        check_value("retired_count", exp_retired, retired_count);
    endtask

    task automatic finish_test(input int errors_before);
        tests_run++;
        if (error_count != errors_before) begin
            tests_failed++;
        end
        $display("test %s finished with %0d errors", test_name, error_count - errors_before);
    endtask

    // Compares every commit edge against the reference model
    always @(negedge clk) begin : compare_commits
        int idx;
        int effect;
        if (!reset) begin
            if (redirect) begin
                redirect_count++;
            end
            if (redirect_due) begin
                check_true(redirect, "redirect missing after an excepting commit");
                check_value("redirect_pc", due_pc, redirect_pc);
                check_value("redirect_miss_addr", due_miss, redirect_miss_addr);
            end else begin
                check_true(!redirect, "redirect pulsed without an excepting commit");
            end
            redirect_due = 1'b0;
            if (i_dut.head_commit) begin
                if (order_q.size() == 0) begin
                    check_true(1'b0, "commit with no entry pending");
                end else begin
                    idx = order_q.pop_front();
                    effect = commit_effect(ref_type[idx], ref_rd[idx], ref_exc[idx]);
                    check_value("head_pc", ref_pc[idx], i_dut.head_pc);
                    check_value("wr_en", effect == eff_write, i_dut.wr_en);
                    if (effect == eff_write) begin
                        check_value("wr_addr", ref_rd[idx], i_dut.wr_addr);
                        check_value("wr_data", ref_value[idx], i_dut.wr_data);
                        shadow[ref_rd[idx]] = ref_value[idx];
                    end
                    if (effect == eff_redirect) begin
                        redirect_due = 1'b1;
                        due_pc = ref_pc[idx];
                        due_miss = ref_miss[idx];
                        order_q.delete();
                        exp_tail = 0;
                    end else begin
                        exp_retired++;
                    end
                end
            end
        end
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < timeout_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run stopped after %0d cycles", cycle_count);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin : stimulus
        int start_errors;
        int start_retired;
        int start_redirects;
        int idx_hold;
        int list[$];
        logic [rob_pkg::exc_w-1:0] exc;
        logic [1:0] sel;
        lfsr_state = 32'h36fdaa58;
        reset = 1'b1;
        alloc = 1'b0;
        alloc_pc = '0;
        alloc_addr_miss = '0;
        alloc_rd = '0;
        alloc_instr_type = rob_pkg::itype_alu;
        stall = 1'b0;
        exe_complete = 1'b0;
        exe_idx = '0;
        exe_value = '0;
        exe_exception = rob_pkg::exc_none;
        cache_complete = 1'b0;
        cache_idx = '0;
        cache_value = '0;
        rs_addr = '0;
        redirect_due = 1'b0;
        exp_tail = 0;
        exp_retired = 0;
        redirect_count = 0;
        error_count = 0;
        tests_run = 0;
        tests_failed = 0;
        foreach (shadow[r]) begin
            shadow[r] = '0;
        end
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        // Twenty allocations in total, so the tail is back at zero afterwards
        test_name = "ooo_commit";
        start_errors = error_count;
        repeat (4) begin
            repeat (5) begin
                sel = 2'(take_bits(2));
                alloc_entry(sel == 2'd0 ? rob_pkg::itype_alu :
                            sel == 2'd1 ? rob_pkg::itype_load : rob_pkg::itype_mul,
                            pick_dest());
            end
            complete_batch();
            drain();
        end
        sweep_regs();
        finish_test(start_errors);

        test_name = "full_backpressure";
        start_errors = error_count;
        start_retired = exp_retired;
        repeat (rob_pkg::rob_size) alloc_entry(rob_pkg::itype_alu, pick_dest());
        @(negedge clk);
        check_true(full, "full low with every entry allocated");
        check_value("alloc_idx at full", 0, alloc_idx);
        @(posedge clk);
        alloc <= 1'b1;
        repeat (3) @(posedge clk);
        alloc <= 1'b0;
        @(negedge clk);
        check_value("alloc_idx after ignored alloc", 0, alloc_idx);
        complete_batch();
        drain();
        check_value("commits", start_retired + rob_pkg::rob_size, retired_count);
        check_value("alloc_idx after drain", 0, alloc_idx);
        sweep_regs();
        finish_test(start_errors);

        test_name = "stall";
        start_errors = error_count;
        start_retired = exp_retired;
        repeat (4) alloc_entry(rob_pkg::itype_mul, pick_dest());
        idx_hold = exp_tail;
        @(posedge clk);
        stall <= 1'b1;
        alloc <= 1'b1;
        complete_batch();
        @(negedge clk);
        check_value("alloc_idx in stall", idx_hold, alloc_idx);
        @(posedge clk);
        stall <= 1'b0;
        alloc <= 1'b0;
        drain();
        check_value("alloc_idx after stall", idx_hold, alloc_idx);
        check_value("commits", start_retired + 4, retired_count);
        sweep_regs();
        finish_test(start_errors);

        test_name = "store_and_x0";
        start_errors = error_count;
        repeat (8) begin
            if (take_bits(1) != 0) begin
                alloc_entry(rob_pkg::itype_store, 5'(take_bits(5)));
            end else begin
                alloc_entry(take_bits(1) != 0 ? rob_pkg::itype_load : rob_pkg::itype_alu, 5'd0);
            end
        end
        complete_batch();
        drain();
        sweep_regs();
        finish_test(start_errors);

        // Third entry faults after the two older ones retire and the three younger complete
        test_name = "exception_flush";
        start_errors = error_count;
        start_retired = exp_retired;
        start_redirects = redirect_count;
        batch.delete();
        repeat (6) alloc_entry(rob_pkg::itype_alu, pick_dest());
        list = batch;
        batch.delete();
        exc = 3'(take_bits(3));
        if (exc == rob_pkg::exc_none) begin
            exc = 3'd7;
        end
        complete_entry(list[3], rob_pkg::exc_none);
        complete_entry(list[4], rob_pkg::exc_none);
        complete_entry(list[5], rob_pkg::exc_none);
        complete_entry(list[0], rob_pkg::exc_none);
        complete_entry(list[1], rob_pkg::exc_none);
        complete_entry(list[2], exc);
        drain();
        @(negedge clk);
        check_value("redirect pulses", start_redirects + 1, redirect_count);
        check_true(!full, "full high after flush");
        check_value("alloc_idx after flush", 0, alloc_idx);
        check_value("commits", start_retired + 2, retired_count);
        sweep_regs();
        finish_test(start_errors);

        $display("tests run %0d, tests with errors %0d, failed checks %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/arch_regfile.sv */
`default_nettype none

module arch_regfile (
    input  logic        clk,
    input  logic        reset,

    // Write port from commit
    input  logic        wr_en,
    input  logic [4:0]  wr_addr,
    input  logic [31:0] wr_data,

    // Read port
    input  logic [4:0]  rs_addr,
    output logic [31:0] rs_data
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != 5'd0)) begin
            // x0 is never written, so it stays zero from reset
            regs[wr_addr] <= wr_data;
        end
    end

    // Combinational read
    assign rs_data = regs[rs_addr];

endmodule

`default_nettype wire

/* verilog/commit_unit.sv */
`default_nettype none

module commit_unit (
    input  logic                         clk,
    input  logic                         reset,

    // Oldest buffer entry
    input  logic                         head_commit,
    input  logic [rob_pkg::exc_w-1:0]    head_exception,
    input  logic [31:0]                  head_value,
    input  logic [4:0]                   head_rd,
    input  logic [rob_pkg::instr_w-1:0]  head_instr_type,
    input  logic [31:0]                  head_pc,
    input  logic [31:0]                  head_miss_addr,

    // Register file write port
    output logic                         wr_en,
    output logic [4:0]                   wr_addr,
    output logic [31:0]                  wr_data,

    // Front end redirect and retire statistics
    output logic                         redirect,
    output logic [31:0]                  redirect_pc,
    output logic [31:0]                  redirect_miss_addr,
    output logic [31:0]                  retired_count
);

    logic clean_commit;
    logic fault_commit;

    assign clean_commit = head_commit && (head_exception == rob_pkg::exc_none);
    assign fault_commit = head_commit && (head_exception != rob_pkg::exc_none);

    // Stores and x0 retire without touching the register file
    assign wr_en   = clean_commit
                     && (head_instr_type != rob_pkg::itype_store)
                     && (head_rd != 5'd0);
    assign wr_addr = head_rd;
    assign wr_data = head_value;

    always_ff @(posedge clk) begin
        if (reset) begin
            redirect      <= 1'b0;
            retired_count <= '0;
        end else begin
            redirect <= fault_commit;
            if (clean_commit) begin
                retired_count <= retired_count + 1'b1;
            end
        end
    end

    // Redirect target, held until the next fault
    always_ff @(posedge clk) begin
        if (fault_commit) begin
            redirect_pc        <= head_pc;
            redirect_miss_addr <= head_miss_addr;
        end
    end

    // The flush empties the buffer, so a second fault cannot follow at once
    a_redirect_single: assert property (@(posedge clk) disable iff (reset)
        redirect |=> !redirect)
        else $error("redirect held for two cycles");

endmodule

`default_nettype wire

/* verilog/reorder_buffer.sv */
`default_nettype none

module reorder_buffer (
    input  logic                         clk,
    input  logic                         reset,

    // Decode side
    input  logic                         alloc,
    input  logic [31:0]                  alloc_pc,
    input  logic [31:0]                  alloc_addr_miss,
    input  logic [4:0]                   alloc_rd,
    input  logic [rob_pkg::instr_w-1:0]  alloc_instr_type,
    input  logic                         stall,
    output logic                         full,
    output logic [rob_pkg::idx_w-1:0]    alloc_idx,

    // Execute completion port
    input  logic                         exe_complete,
    input  logic [rob_pkg::idx_w-1:0]    exe_idx,
    input  logic [31:0]                  exe_value,
    input  logic [rob_pkg::exc_w-1:0]    exe_exception,

    // Cache completion port, load data only
    input  logic                         cache_complete,
    input  logic [rob_pkg::idx_w-1:0]    cache_idx,
    input  logic [31:0]                  cache_value,

    // Oldest entry, toward the commit unit
    output logic                         head_commit,
    output logic [rob_pkg::exc_w-1:0]    head_exception,
    output logic [31:0]                  head_value,
    output logic [4:0]                   head_rd,
    output logic [rob_pkg::instr_w-1:0]  head_instr_type,
    output logic [31:0]                  head_pc,
    output logic [31:0]                  head_miss_addr
);

    localparam logic [rob_pkg::idx_w-1:0] last_idx = rob_pkg::idx_w'(rob_pkg::rob_size - 1);

    // Entry payload
    logic [31:0]                 pc_mem        [rob_pkg::rob_size];
    logic [31:0]                 miss_mem      [rob_pkg::rob_size];
    logic [31:0]                 value_mem     [rob_pkg::rob_size];
    logic [4:0]                  rd_mem        [rob_pkg::rob_size];
    logic [rob_pkg::instr_w-1:0] type_mem      [rob_pkg::rob_size];
    logic [rob_pkg::exc_w-1:0]   exception_mem [rob_pkg::rob_size];

    // Entry state
    logic [rob_pkg::rob_size-1:0] valid;
    logic [rob_pkg::rob_size-1:0] complete;

    logic [rob_pkg::idx_w-1:0] head;
    logic [rob_pkg::idx_w-1:0] tail;
    logic [rob_pkg::idx_w-1:0] count;

    logic alloc_fire;
    logic flush;
    logic release_head;

    function automatic logic [rob_pkg::idx_w-1:0] next_idx(input logic [rob_pkg::idx_w-1:0] idx);
        return (idx == last_idx) ? '0 : idx + 1'b1;
    endfunction

    assign full      = (count == rob_pkg::rob_size);
    assign alloc_idx = tail;

    assign alloc_fire   = alloc && !full && !stall;
    assign head_commit  = valid[head] && complete[head];
    assign flush        = head_commit && (exception_mem[head] != rob_pkg::exc_none);
    assign release_head = head_commit && !flush;

    // Head entry straight out of the arrays
    assign head_exception  = exception_mem[head];
    assign head_value      = value_mem[head];
    assign head_rd         = rd_mem[head];
    assign head_instr_type = type_mem[head];
    assign head_pc         = pc_mem[head];
    assign head_miss_addr  = miss_mem[head];

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head     <= '0;
            tail     <= '0;
            count    <= '0;
            valid    <= '0;
            complete <= '0;
        end else begin
            if (alloc_fire) begin
                valid[tail]    <= 1'b1;
                complete[tail] <= 1'b0;
                tail           <= next_idx(tail);
            end
            if (exe_complete) begin
                complete[exe_idx] <= 1'b1;
            end
            if (cache_complete) begin
                complete[cache_idx] <= 1'b1;
            end
            // Release last so it wins over a late completion to the head
            if (release_head) begin
                valid[head]    <= 1'b0;
                complete[head] <= 1'b0;
                head           <= next_idx(head);
            end
            case ({alloc_fire, release_head})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            pc_mem[tail]   <= alloc_pc;
            miss_mem[tail] <= alloc_addr_miss;
            rd_mem[tail]   <= alloc_rd;
            type_mem[tail] <= alloc_instr_type;
        end
        if (exe_complete) begin
            value_mem[exe_idx]     <= exe_value;
            exception_mem[exe_idx] <= exe_exception;
        end
        if (cache_complete) begin
            value_mem[cache_idx]     <= cache_value;
            exception_mem[cache_idx] <= rob_pkg::exc_none;
        end
    end

    // Completions must name a live entry
    a_exe_target_valid: assert property (@(posedge clk) disable iff (reset)
        exe_complete |-> (exe_idx < rob_pkg::rob_size) && valid[exe_idx])
        else $error("execute completion to invalid entry %0d", exe_idx);

    a_cache_target_valid: assert property (@(posedge clk) disable iff (reset)
        cache_complete |-> (cache_idx < rob_pkg::rob_size) && valid[cache_idx])
        else $error("cache completion to invalid entry %0d", cache_idx);

    a_port_collision: assert property (@(posedge clk) disable iff (reset)
        !(exe_complete && cache_complete && (exe_idx == cache_idx)))
        else $error("both completion ports hit entry %0d", exe_idx);

    a_count_bound: assert property (@(posedge clk) disable iff (reset)
        count <= rob_pkg::rob_size)
        else $error("entry count %0d above buffer size", count);

endmodule

`default_nettype wire

/* verilog/rob_core_top.sv */
`default_nettype none

module rob_core_top (
    input  logic                         clk,
    input  logic                         reset,

    // Decode
    input  logic                         alloc,
    input  logic [31:0]                  alloc_pc,
    input  logic [31:0]                  alloc_addr_miss,
    input  logic [4:0]                   alloc_rd,
    input  logic [rob_pkg::instr_w-1:0]  alloc_instr_type,
    input  logic                         stall,
    output logic                         full,
    output logic [rob_pkg::idx_w-1:0]    alloc_idx,

    // Execute and cache completions
    input  logic                         exe_complete,
    input  logic [rob_pkg::idx_w-1:0]    exe_idx,
    input  logic [31:0]                  exe_value,
    input  logic [rob_pkg::exc_w-1:0]    exe_exception,
    input  logic                         cache_complete,
    input  logic [rob_pkg::idx_w-1:0]    cache_idx,
    input  logic [31:0]                  cache_value,

    // Architectural read port
    input  logic [4:0]                   rs_addr,
    output logic [31:0]                  rs_data,

    // Retirement outputs
    output logic                         redirect,
    output logic [31:0]                  redirect_pc,
    output logic [31:0]                  redirect_miss_addr,
    output logic [31:0]                  retired_count
);

    // Buffer head toward commit
    logic                        head_commit;
    logic [rob_pkg::exc_w-1:0]   head_exception;
    logic [31:0]                 head_value;
    logic [4:0]                  head_rd;
    logic [rob_pkg::instr_w-1:0] head_instr_type;
    logic [31:0]                 head_pc;
    logic [31:0]                 head_miss_addr;

    // Commit toward register file
    logic        wr_en;
    logic [4:0]  wr_addr;
    logic [31:0] wr_data;

    reorder_buffer i_rob (
        .clk              (clk),
        .reset            (reset),
        .alloc            (alloc),
        .alloc_pc         (alloc_pc),
        .alloc_addr_miss  (alloc_addr_miss),
        .alloc_rd         (alloc_rd),
        .alloc_instr_type (alloc_instr_type),
        .stall            (stall),
        .full             (full),
        .alloc_idx        (alloc_idx),
        .exe_complete     (exe_complete),
        .exe_idx          (exe_idx),
        .exe_value        (exe_value),
        .exe_exception    (exe_exception),
        .cache_complete   (cache_complete),
        .cache_idx        (cache_idx),
        .cache_value      (cache_value),
        .head_commit      (head_commit),
        .head_exception   (head_exception),
        .head_value       (head_value),
        .head_rd          (head_rd),
        .head_instr_type  (head_instr_type),
        .head_pc          (head_pc),
        .head_miss_addr   (head_miss_addr)
    );

    commit_unit i_commit (
        .clk                (clk),
        .reset              (reset),
        .head_commit        (head_commit),
        .head_exception     (head_exception),
        .head_value         (head_value),
        .head_rd            (head_rd),
        .head_instr_type    (head_instr_type),
        .head_pc            (head_pc),
        .head_miss_addr     (head_miss_addr),
        .wr_en              (wr_en),
        .wr_addr            (wr_addr),
        .wr_data            (wr_data),
        .redirect           (redirect),
        .redirect_pc        (redirect_pc),
        .redirect_miss_addr (redirect_miss_addr),
        .retired_count      (retired_count)
    );

    arch_regfile i_regfile (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rs_addr (rs_addr),
        .rs_data (rs_data)
    );

endmodule

`default_nettype wire

/* verilog/rob_pkg.sv */
`default_nettype none

package rob_pkg;

    // Reorder buffer geometry
    localparam int rob_size = 10;
    localparam int idx_w    = 4;

    // Field widths carried through the buffer
    localparam int instr_w = 3;
    localparam int exc_w   = 3;

    // Exception code for a clean completion
    localparam logic [exc_w-1:0] exc_none = '0;

    // Instruction types seen at retirement
    localparam logic [instr_w-1:0] itype_alu   = 3'd0;
    localparam logic [instr_w-1:0] itype_load  = 3'd1;
    localparam logic [instr_w-1:0] itype_store = 3'd2;
    localparam logic [instr_w-1:0] itype_mul   = 3'd3;

endpackage

`default_nettype wire

/* vlog.f */
verilog/rob_pkg.sv
verilog/reorder_buffer.sv
verilog/commit_unit.sv
verilog/arch_regfile.sv
verilog/rob_core_top.sv
dv/tb_rob_core.sv
